/* hdl/chroma_interp.sv */
`default_nettype none

module chroma_interp (
    input  logic                        clk_p,
    input  demosaic_pkg::chroma_op_t    op,
    input  demosaic_pkg::cross_t        g_cross,
    input  demosaic_pkg::cross_t        r_cross,
    input  demosaic_pkg::cross_t        b_cross,
    input  demosaic_pkg::diag_t         g_diag,
    input  demosaic_pkg::diag_t         r_diag,
    input  demosaic_pkg::diag_t         b_diag,
    output demosaic_pkg::pix_t          c_value
);
    import demosaic_pkg::*;

    pix_t [3:0] t_nb, g_nb;
    logic signed [pix_w+3:0] acc;
    sdiff_t est;
    pix_t sat;

    function automatic sdiff_t cdiff(pix_t t, pix_t g);
        return sdiff_t'({2'b00, t}) - sdiff_t'({2'b00, g});
    endfunction

    always_comb begin
        // diagonals at red and blue sites, cross at green sites
        case (op)
            op_r_at_b: begin
                t_nb = {r_diag.nw, r_diag.ne, r_diag.sw, r_diag.se};
                g_nb = {g_diag.nw, g_diag.ne, g_diag.sw, g_diag.se};
            end
            op_b_at_r: begin
                t_nb = {b_diag.nw, b_diag.ne, b_diag.sw, b_diag.se};
                g_nb = {g_diag.nw, g_diag.ne, g_diag.sw, g_diag.se};
            end
            op_r_at_g: begin
                t_nb = {r_cross.n, r_cross.s, r_cross.w, r_cross.e};
                g_nb = {g_cross.n, g_cross.s, g_cross.w, g_cross.e};
            end
            default: begin
                t_nb = {b_cross.n, b_cross.s, b_cross.w, b_cross.e};
                g_nb = {g_cross.n, g_cross.s, g_cross.w, g_cross.e};
            end
        endcase
        acc = cdiff(t_nb[0], g_nb[0]) + cdiff(t_nb[1], g_nb[1])
            + cdiff(t_nb[2], g_nb[2]) + cdiff(t_nb[3], g_nb[3]);
        // floor shift, range stays within -255..510
        est = sdiff_t'(sdiff_t'({2'b00, g_cross.c}) + (acc >>> 2));
        if (est < 0) sat = '0;
        else if (est > 255) sat = '1;
        else sat = est[pix_w-1:0];
    end

    always_ff @(posedge clk_p) begin
        c_value <= sat;
    end

endmodule

`default_nettype wire

/* hdl/demosaic_pkg.sv */
`default_nettype none

package demosaic_pkg;

    localparam int pix_w = 8;
    localparam int num_w = 38;
    localparam int den_w = 29;

    typedef logic [pix_w-1:0] pix_t;
    typedef logic signed [pix_w+1:0] sdiff_t;

    typedef struct packed {
        pix_t r;
        pix_t g;
        pix_t b;
    } rgb_t;

    // [row][col], row 0 is two lines above the centre
    typedef logic [0:4][0:4][pix_w-1:0] win5_t;

    typedef struct packed {
        pix_t c;
        pix_t n;
        pix_t s;
        pix_t w;
        pix_t e;
    } cross_t;

    typedef struct packed {
        pix_t nw;
        pix_t ne;
        pix_t sw;
        pix_t se;
    } diag_t;

    typedef enum logic [3:0] {
        ph_idle, ph_load, ph_green, ph_r_at_b, ph_b_at_r,
        ph_r_at_g, ph_b_at_g, ph_emit, ph_done
    } phase_t;

    typedef enum logic [1:0] {
        op_r_at_b, op_b_at_r, op_r_at_g, op_b_at_g
    } chroma_op_t;

endpackage

`default_nettype wire

/* hdl/demosaic_top.sv */
`default_nettype none

module demosaic_top #(
    parameter int img_w = 16,
    parameter int img_h = 12
) (
    input  logic                              clk_p,
    input  logic                              rst,
    input  logic                              start,
    input  demosaic_pkg::pix_t                rd_data,
    output logic [$clog2(img_w*img_h)-1:0]    rd_addr,
    output logic [$clog2(img_w*img_h)-1:0]    wr_addr,
    output demosaic_pkg::rgb_t                pixel_out,
    output logic                              out_valid,
    output logic                              done
);
    import demosaic_pkg::*;

    localparam int xw = $clog2(img_w);
    localparam int yw = $clog2(img_h);

    logic raw_we, g_we, r_we, b_we;
    logic [xw-1:0] wx, cx;
    logic [yw-1:0] wy, cy;
    win5_t raw_win;
    cross_t g_cross, r_cross, b_cross;
    diag_t g_diag, r_diag, b_diag;
    logic go, g_valid, div_start, div_done;
    pix_t g_value, c_value;
    chroma_op_t op;
    logic [num_w-1:0] num, quot;
    logic [den_w-1:0] den;

    frame_store #(.img_w(img_w), .img_h(img_h)) u_store (
        .clk_p(clk_p), .raw_we(raw_we), .g_we(g_we), .r_we(r_we), .b_we(b_we),
        .wx(wx), .wy(wy), .cx(cx), .cy(cy),
        .raw_in(rd_data), .g_in(g_value), .r_in(c_value), .b_in(c_value),
        .raw_win(raw_win), .g_cross(g_cross), .r_cross(r_cross), .b_cross(b_cross),
        .g_diag(g_diag), .r_diag(r_diag), .b_diag(b_diag), .rgb_at(pixel_out)
    );

    raster_sequencer #(.img_w(img_w), .img_h(img_h)) u_seq (
        .clk_p(clk_p), .rst(rst), .start(start), .g_valid(g_valid),
        .rd_addr(rd_addr), .wr_addr(wr_addr), .out_valid(out_valid), .done(done),
        .raw_we(raw_we), .g_we(g_we), .r_we(r_we), .b_we(b_we),
        .wx(wx), .wy(wy), .cx(cx), .cy(cy), .go(go), .op(op)
    );

    green_interp u_green (
        .clk_p(clk_p), .rst(rst), .go(go), .raw_win(raw_win),
        .quot(quot), .div_done(div_done), .num(num), .den(den),
        .div_start(div_start), .g_valid(g_valid), .g_value(g_value)
    );

    ratio_divider u_div (
        .clk_p(clk_p), .rst(rst), .div_start(div_start),
        .num(num), .den(den), .quot(quot), .div_done(div_done)
    );

    chroma_interp u_chroma (
        .clk_p(clk_p), .op(op),
        .g_cross(g_cross), .r_cross(r_cross), .b_cross(b_cross),
        .g_diag(g_diag), .r_diag(r_diag), .b_diag(b_diag), .c_value(c_value)
    );

endmodule

`default_nettype wire

/* hdl/frame_store.sv */
`default_nettype none

module frame_store #(
    parameter int img_w = 16,
    parameter int img_h = 12
) (
    input  logic                        clk_p,
    input  logic                        raw_we,
    input  logic                        g_we,
    input  logic                        r_we,
    input  logic                        b_we,
    input  logic [$clog2(img_w)-1:0]    wx,
    input  logic [$clog2(img_h)-1:0]    wy,
    input  logic [$clog2(img_w)-1:0]    cx,
    input  logic [$clog2(img_h)-1:0]    cy,
    input  demosaic_pkg::pix_t          raw_in,
    input  demosaic_pkg::pix_t          g_in,
    input  demosaic_pkg::pix_t          r_in,
    input  demosaic_pkg::pix_t          b_in,
    output demosaic_pkg::win5_t         raw_win,
    output demosaic_pkg::cross_t        g_cross,
    output demosaic_pkg::cross_t        r_cross,
    output demosaic_pkg::cross_t        b_cross,
    output demosaic_pkg::diag_t         g_diag,
    output demosaic_pkg::diag_t         r_diag,
    output demosaic_pkg::diag_t         b_diag,
    output demosaic_pkg::rgb_t          rgb_at
);
    import demosaic_pkg::*;

    localparam int depth = img_w * img_h;
    localparam int aw = $clog2(depth);
    localparam int row = img_w;

    pix_t raw_m [depth];
    pix_t r_m [depth];
    pix_t g_m [depth];
    pix_t b_m [depth];

    logic [aw-1:0] wa;
    int ca;

    assign wa = aw'(int'(wy) * img_w + int'(wx));
    assign ca = int'(cy) * img_w + int'(cx);

    // ------------------------------
    // write ports
    always_ff @(posedge clk_p) begin
        if (raw_we) begin
            raw_m[wa] <= raw_in;
            r_m[wa] <= (!wx[0] && !wy[0]) ? raw_in : '0;
            b_m[wa] <= (wx[0] && wy[0]) ? raw_in : '0;
            g_m[wa] <= (wx[0] ^ wy[0]) ? raw_in : '0;
        end
        if (g_we) g_m[wa] <= g_in;
        if (r_we) r_m[wa] <= r_in;
        if (b_we) b_m[wa] <= b_in;
    end

    // ------------------------------
    // neighbour windows around (cx, cy)
    always_comb begin
        for (int r = 0; r < 5; r++) begin
            for (int c = 0; c < 5; c++) begin
                raw_win[r][c] = raw_m[ca + (r - 2) * row + (c - 2)];
            end
        end
    end

    assign g_cross = '{c: g_m[ca], n: g_m[ca-row], s: g_m[ca+row], w: g_m[ca-1], e: g_m[ca+1]};
    assign r_cross = '{c: r_m[ca], n: r_m[ca-row], s: r_m[ca+row], w: r_m[ca-1], e: r_m[ca+1]};
    assign b_cross = '{c: b_m[ca], n: b_m[ca-row], s: b_m[ca+row], w: b_m[ca-1], e: b_m[ca+1]};

    assign g_diag = '{nw: g_m[ca-row-1], ne: g_m[ca-row+1], sw: g_m[ca+row-1], se: g_m[ca+row+1]};
    assign r_diag = '{nw: r_m[ca-row-1], ne: r_m[ca-row+1], sw: r_m[ca+row-1], se: r_m[ca+row+1]};
    assign b_diag = '{nw: b_m[ca-row-1], ne: b_m[ca-row+1], sw: b_m[ca+row-1], se: b_m[ca+row+1]};

    assign rgb_at = '{r: r_m[ca], g: g_m[ca], b: b_m[ca]};

endmodule

`default_nettype wire

/* hdl/green_interp.sv */
`default_nettype none

module green_interp (
    input  logic                                clk_p,
    input  logic                                rst,
    input  logic                                go,
    input  demosaic_pkg::win5_t                 raw_win,
    input  logic [demosaic_pkg::num_w-1:0]      quot,
    input  logic                                div_done,
    output logic [demosaic_pkg::num_w-1:0]      num,
    output logic [demosaic_pkg::den_w-1:0]      den,
    output logic                                div_start,
    output logic                                g_valid,
    output demosaic_pkg::pix_t                  g_value
);
    import demosaic_pkg::*;

    // gradients reach 256 and estimates 382, so one extra bit
    typedef logic [pix_w:0] grad_t;
    typedef logic [3*pix_w:0] prod_t;

    grad_t u_n, u_s, u_w, u_e;
    grad_t e_n, e_s, e_w, e_e;
    prod_t p_n, p_s, p_w, p_e;
    logic v1, v2;

    function automatic pix_t absd(pix_t a, pix_t b);
        return (a > b) ? a - b : b - a;
    endfunction

    function automatic grad_t grad(pix_t d0, pix_t d1, pix_t d2, pix_t d3);
        logic [pix_w+1:0] s;
        s = d0 + d1 + d2 + d3;
        return grad_t'(s >> 2) + grad_t'(1);
    endfunction

    function automatic grad_t est(pix_t adj, pix_t c, pix_t far);
        return grad_t'(adj) + grad_t'(absd(c, far) >> 1);
    endfunction

    // ------------------------------
    // stage 1: directional gradients and estimates
    always_ff @(posedge clk_p) begin
        if (go) begin
            u_n <= grad(absd(raw_win[2][1], raw_win[0][1]), absd(raw_win[2][2], raw_win[0][2]),
                        absd(raw_win[2][3], raw_win[0][3]), absd(raw_win[3][2], raw_win[1][2]));
            u_s <= grad(absd(raw_win[2][1], raw_win[4][1]), absd(raw_win[2][2], raw_win[4][2]),
                        absd(raw_win[2][3], raw_win[4][3]), absd(raw_win[3][2], raw_win[1][2]));
            u_w <= grad(absd(raw_win[1][0], raw_win[1][2]), absd(raw_win[2][0], raw_win[2][2]),
                        absd(raw_win[3][0], raw_win[3][2]), absd(raw_win[2][3], raw_win[2][1]));
            u_e <= grad(absd(raw_win[1][4], raw_win[1][2]), absd(raw_win[2][4], raw_win[2][2]),
                        absd(raw_win[3][4], raw_win[3][2]), absd(raw_win[2][3], raw_win[2][1]));
            e_n <= est(raw_win[1][2], raw_win[2][2], raw_win[0][2]);
            e_s <= est(raw_win[3][2], raw_win[2][2], raw_win[4][2]);
            e_w <= est(raw_win[2][1], raw_win[2][2], raw_win[2][0]);
            e_e <= est(raw_win[2][3], raw_win[2][2], raw_win[2][4]);
        end
        // stage 2: weight of each direction is the product of the other three
        if (v1) begin
            p_n <= u_s * u_w * u_e;
            p_s <= u_n * u_w * u_e;
            p_w <= u_n * u_s * u_e;
            p_e <= u_n * u_s * u_w;
        end
        // stage 3: blend numerator and denominator
        if (v2) begin
            num <= e_n * p_n + e_s * p_s + e_w * p_w + e_e * p_e;
            den <= p_n + p_s + p_w + p_e;
        end
        if (div_done) begin
            g_value <= (|quot[num_w-1:pix_w]) ? '1 : quot[pix_w-1:0];
        end
    end

    always_ff @(posedge clk_p or posedge rst) begin
        if (rst) begin
            v1 <= 1'b0;
            v2 <= 1'b0;
            div_start <= 1'b0;
            g_valid <= 1'b0;
        end else begin
            v1 <= go;
            v2 <= v1;
            div_start <= v2;
            g_valid <= div_done;
        end
    end

endmodule

`default_nettype wire

/* hdl/raster_sequencer.sv */
`default_nettype none

module raster_sequencer #(
    parameter int img_w = 16,
    parameter int img_h = 12
) (
    input  logic                              clk_p,
    input  logic                              rst,
    input  logic                              start,
    input  logic                              g_valid,
    output logic [$clog2(img_w*img_h)-1:0]    rd_addr,
    output logic [$clog2(img_w*img_h)-1:0]    wr_addr,
    output logic                              out_valid,
    output logic                              done,
    output logic                              raw_we,
    output logic                              g_we,
    output logic                              r_we,
    output logic                              b_we,
    output logic [$clog2(img_w)-1:0]          wx,
    output logic [$clog2(img_h)-1:0]          wy,
    output logic [$clog2(img_w)-1:0]          cx,
    output logic [$clog2(img_h)-1:0]          cy,
    output logic                              go,
    output demosaic_pkg::chroma_op_t          op
);
    import demosaic_pkg::*;

    localparam int aw = $clog2(img_w * img_h);
    localparam int xw = $clog2(img_w);
    localparam int yw = $clog2(img_h);
    localparam int x_hi = img_w - 3;
    localparam int y_hi = img_h - 3;

    phase_t phase, np;
    logic [xw-1:0] x, nx;
    logic [yw-1:0] y, ny;
    logic [1:0] xs;
    logic hold, advance, row_end, pass_end, chroma_ph;
    logic [aw-1:0] addr;

    // x of the first site on a row for each pass
    function automatic int row_start(phase_t ph, int yy);
        case (ph)
            ph_green:             return yy[0] ? 3 : 2;
            ph_r_at_b:            return 3;
            ph_r_at_g, ph_b_at_g: return yy[0] ? 2 : 3;
            default:              return 2;
        endcase
    endfunction

    function automatic int first_row(phase_t ph);
        return (ph == ph_r_at_b) ? 3 : 2;
    endfunction

    function automatic int row_step(phase_t ph);
        return (ph == ph_r_at_b || ph == ph_b_at_r) ? 2 : 1;
    endfunction

    // ------------------------------
    // next site in the current pass
    always_comb begin
        xs = (phase == ph_emit) ? 2'd1 : 2'd2;
        row_end = int'(x) + xs > x_hi;
        pass_end = row_end && (int'(y) + row_step(phase) > y_hi);
        ny = row_end ? yw'(int'(y) + row_step(phase)) : y;
        nx = row_end ? xw'(row_start(phase, int'(ny))) : xw'(int'(x) + xs);
        np = (phase == ph_emit) ? ph_done : phase_t'(phase + 1'b1);
        chroma_ph = phase inside {ph_r_at_b, ph_b_at_r, ph_r_at_g, ph_b_at_g};
        case (phase)
            ph_green: advance = hold && g_valid;
            ph_emit:  advance = 1'b1;
            default:  advance = chroma_ph && hold;
        endcase
    end

    // ------------------------------
    // phase FSM
    always_ff @(posedge clk_p or posedge rst) begin
        if (rst) begin
            phase <= ph_idle;
            x <= '0;
            y <= '0;
            hold <= 1'b0;
            go <= 1'b0;
            raw_we <= 1'b0;
        end else begin
            go <= 1'b0;
            // RAM data lags its address by one cycle
            raw_we <= (phase == ph_load);
            case (phase)
                ph_idle, ph_done: begin
                    if (start) begin
                        phase <= ph_load;
                        x <= '0;
                        y <= '0;
                    end
                end
                ph_load: begin
                    if (int'(x) == img_w - 1) begin
                        x <= '0;
                        y <= y + 1'b1;
                        if (int'(y) == img_h - 1) begin
                            phase <= ph_green;
                            x <= xw'(2);
                            y <= yw'(2);
                        end
                    end else begin
                        x <= x + 1'b1;
                    end
                end
                default: begin
                    // green waits on the divider, chroma takes two cycles
                    if (!hold && phase != ph_emit) begin
                        hold <= 1'b1;
                        go <= (phase == ph_green);
                    end
                    if (advance) begin
                        hold <= 1'b0;
                        if (pass_end) begin
                            phase <= np;
                            y <= yw'(first_row(np));
                            x <= xw'(row_start(np, first_row(np)));
                        end else begin
                            x <= nx;
                            y <= ny;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_p) begin
        wx <= x;
        wy <= y;
    end

    assign addr = aw'(int'(y) * img_w + int'(x));
    assign rd_addr = (phase == ph_load) ? addr : '0;
    assign wr_addr = (phase == ph_emit) ? addr : '0;
    assign out_valid = (phase == ph_emit);
    assign done = (phase == ph_done);
    assign cx = x;
    assign cy = y;
    assign g_we = (phase == ph_green) && g_valid;
    assign r_we = hold && (phase == ph_r_at_b || phase == ph_r_at_g);
    assign b_we = hold && (phase == ph_b_at_r || phase == ph_b_at_g);

    always_comb begin
        case (phase)
            ph_b_at_r: op = op_b_at_r;
            ph_r_at_g: op = op_r_at_g;
            ph_b_at_g: op = op_b_at_g;
            default:   op = op_r_at_b;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/ratio_divider.sv */
`default_nettype none

module ratio_divider (
    input  logic                                clk_p,
    input  logic                                rst,
    input  logic                                div_start,
    input  logic [demosaic_pkg::num_w-1:0]      num,
    input  logic [demosaic_pkg::den_w-1:0]      den,
    output logic [demosaic_pkg::num_w-1:0]      quot,
    output logic                                div_done
);
    import demosaic_pkg::*;

    logic [den_w-1:0] rem, rem_src, rem_nx, dvs, dvs_src;
    logic [num_w-1:0] q_src, q_nx;
    logic [den_w:0] trial;
    logic [$clog2(num_w)-1:0] cnt;
    logic busy;

    // one restoring step; the start cycle already does the first bit
    always_comb begin
        rem_src = div_start ? '0 : rem;
        q_src = div_start ? num : quot;
        dvs_src = div_start ? den : dvs;
        trial = {rem_src, q_src[num_w-1]};
        if (trial >= {1'b0, dvs_src}) begin
            rem_nx = den_w'(trial - {1'b0, dvs_src});
            q_nx = {q_src[num_w-2:0], 1'b1};
        end else begin
            rem_nx = trial[den_w-1:0];
            q_nx = {q_src[num_w-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk_p) begin
        if (div_start || busy) begin
            rem <= rem_nx;
            quot <= q_nx;
        end
        if (div_start) dvs <= den;
    end

    always_ff @(posedge clk_p or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            cnt <= '0;
            div_done <= 1'b0;
        end else begin
            div_done <= 1'b0;
            if (div_start) begin
                busy <= 1'b1;
                cnt <= ($clog2(num_w))'(num_w - 1);
            end else if (busy) begin
                cnt <= cnt - 1'b1;
                if (cnt == 1) begin
                    busy <= 1'b0;
                    div_done <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+verif
hdl/demosaic_pkg.sv
hdl/frame_store.sv
hdl/raster_sequencer.sv
hdl/green_interp.sv
hdl/ratio_divider.sv
hdl/chroma_interp.sv
hdl/demosaic_top.sv
verif/tb_clock.sv
verif/demosaic_chk.sv
verif/tb_top.sv

/* verif/demosaic_chk.sv */
`default_nettype none

module demosaic_chk #(
    parameter int img_w = 16,
    parameter int img_h = 12
) (
    input logic                              clk_p,
    input logic                              rst,
    input logic                              start,
    input logic                              out_valid,
    input logic                              done,
    input logic [$clog2(img_w*img_h)-1:0]    wr_addr
);
    logic running;
    int col;
    int line;

    // a frame runs from an accepted start until done
    always_ff @(posedge clk_p or posedge rst) begin
        if (rst) begin
            running <= 1'b0;
        end else if (start && !running) begin
            running <= 1'b1;
        end else if (done) begin
            running <= 1'b0;
        end
    end

    always_comb begin
        col = int'(wr_addr) % img_w;
        line = int'(wr_addr) / img_w;
    end

    no_valid_with_done: assert property (@(posedge clk_p) disable iff (rst)
        !(out_valid && done))
        else $error("out_valid and done are high together");

    addr_in_region: assert property (@(posedge clk_p) disable iff (rst)
        out_valid |-> (col >= 2 && col <= img_w - 3 && line >= 2 && line <= img_h - 3))
        else $error("wr_addr outside the interior region");

    start_ignored: assert property (@(posedge clk_p) disable iff (rst)
        (start && running && !out_valid && !done) |=> !done)
        else $error("start during processing raised done");

endmodule

bind demosaic_top demosaic_chk #(.img_w(img_w), .img_h(img_h)) u_chk (
    .clk_p(clk_p), .rst(rst), .start(start),
    .out_valid(out_valid), .done(done), .wr_addr(wr_addr)
);

`default_nettype wire

/* verif/tb_clock.sv */
`default_nettype none

module tb_clock #(
    parameter int period = 10
) (
    output logic clk_p
);

    initial begin
        clk_p = 1'b0;
        forever #(period / 2) clk_p = ~clk_p;
    end

endmodule

`default_nettype wire

/* verif/demosaic_model.svh */
`ifndef demosaic_model_svh
`define demosaic_model_svh

// ------------------------------
// reference model of the demosaic passes, works on ram and mr, mg, mb

function automatic int raw_at(int x, int y);
    return int'(ram[y * img_w + x]);
endfunction

function automatic int abs_diff(int a, int b);
    return (a > b) ? a - b : b - a;
endfunction

// 0 red, 1 green, 2 blue
function automatic int site_of(int x, int y);
    if (x % 2 == 0 && y % 2 == 0) return 0;
    if (x % 2 == 1 && y % 2 == 1) return 2;
    return 1;
endfunction

// gradient toward (dx, dy): three pairs two steps apart plus the straddling pair
function automatic int dir_grad(int x, int y, int dx, int dy);
    int px;
    int py;
    int s;
    px = dy * dy;
    py = dx * dx;
    s = abs_diff(raw_at(x - dx, y - dy), raw_at(x + dx, y + dy));
    for (int k = -1; k <= 1; k++) begin
        s += abs_diff(raw_at(x + k * px, y + k * py),
                      raw_at(x + k * px + 2 * dx, y + k * py + 2 * dy));
    end
    return s / 4 + 1;
endfunction

function automatic int dir_est(int x, int y, int dx, int dy);
    return raw_at(x + dx, y + dy)
        + abs_diff(raw_at(x, y), raw_at(x + 2 * dx, y + 2 * dy)) / 2;
endfunction

function automatic int green_at(int x, int y);
    int dxs [4] = '{0, 0, -1, 1};
    int dys [4] = '{-1, 1, 0, 0};
    longint u [4];
    longint e [4];
    longint w;
    longint num;
    longint den;
    num = 0;
    den = 0;
    for (int i = 0; i < 4; i++) begin
        u[i] = dir_grad(x, y, dxs[i], dys[i]);
        e[i] = dir_est(x, y, dxs[i], dys[i]);
    end
    // each direction weighted by the product of the other gradients
    for (int i = 0; i < 4; i++) begin
        w = 1;
        for (int j = 0; j < 4; j++) begin
            if (j != i) w = w * u[j];
        end
        num += e[i] * w;
        den += w;
    end
    return (num / den > 255) ? 255 : int'(num / den);
endfunction

function automatic int plane_at(int sel, int x, int y);
    case (sel)
        0: return mr[y * img_w + x];
        1: return mg[y * img_w + x];
        default: return mb[y * img_w + x];
    endcase
endfunction

function automatic int chroma_at(int sel, int x, int y, bit diag);
    int ox [4] = '{0, 0, -1, 1};
    int oy [4] = '{-1, 1, 0, 0};
    int acc;
    int nx;
    int ny;
    int v;
    acc = 0;
    for (int i = 0; i < 4; i++) begin
        nx = diag ? x + ((i % 2 == 0) ? -1 : 1) : x + ox[i];
        ny = diag ? y + ((i < 2) ? -1 : 1) : y + oy[i];
        acc += plane_at(sel, nx, ny) - plane_at(1, nx, ny);
    end
    v = plane_at(1, x, y) + (acc >>> 2);
    return (v < 0) ? 0 : ((v > 255) ? 255 : v);
endfunction

function automatic void chroma_pass(int site, int sel);
    for (int y = 2; y <= img_h - 3; y++) begin
        for (int x = 2; x <= img_w - 3; x++) begin
            if (site_of(x, y) == site) begin
                if (sel == 0) mr[y * img_w + x] = chroma_at(0, x, y, site != 1);
                else mb[y * img_w + x] = chroma_at(2, x, y, site != 1);
            end
        end
    end
endfunction

function automatic void build_model();
    for (int a = 0; a < depth; a++) begin
        mr[a] = (site_of(a % img_w, a / img_w) == 0) ? int'(ram[a]) : 0;
        mg[a] = (site_of(a % img_w, a / img_w) == 1) ? int'(ram[a]) : 0;
        mb[a] = (site_of(a % img_w, a / img_w) == 2) ? int'(ram[a]) : 0;
    end
    for (int y = 2; y <= img_h - 3; y++) begin
        for (int x = 2; x <= img_w - 3; x++) begin
            if (site_of(x, y) != 1) mg[y * img_w + x] = green_at(x, y);
        end
    end
    chroma_pass(2, 0);
    chroma_pass(0, 2);
    chroma_pass(1, 0);
    chroma_pass(1, 2);
endfunction

`endif

/* verif/tb_top.sv */
`default_nettype none

module tb_top;
    import demosaic_pkg::*;

    localparam int img_w = 16;
    localparam int img_h = 12;
    localparam int depth = img_w * img_h;
    localparam int aw = $clog2(depth);
    localparam int beats = (img_w - 4) * (img_h - 4);
    localparam int n_rows = 5;
    localparam int clk_period = 10;
    // each interior site bounded by a full green divide plus overhead
    localparam int frame_cycles = depth + 2 * beats * (num_w + 12);

    typedef enum int {k_flat, k_ramp, k_stripes, k_random, k_checker} img_kind_t;

    typedef struct {
        img_kind_t kind;
        int param;
        int count;
    } stim_row_t;

    logic clk_p;
    logic rst;
    logic start;
    pix_t rd_data;
    logic [aw-1:0] rd_addr;
    logic [aw-1:0] wr_addr;
    logic [aw-1:0] addr_q;
    rgb_t pixel_out;
    logic out_valid;
    logic done;

    pix_t ram [depth];
    int mr [depth];
    int mg [depth];
    int mb [depth];
    stim_row_t table_rows [n_rows];
    int errors;
    int checks;

    `include "demosaic_model.svh"

    tb_clock #(.period(clk_period)) u_clock (.clk_p(clk_p));

    demosaic_top #(.img_w(img_w), .img_h(img_h)) DUT (
        .clk_p(clk_p), .rst(rst), .start(start), .rd_data(rd_data),
        .rd_addr(rd_addr), .wr_addr(wr_addr), .pixel_out(pixel_out),
        .out_valid(out_valid), .done(done)
    );

    // raw RAM model answers one cycle after the address
    always @(negedge clk_p) begin
        addr_q = rd_addr;
    end

    always @(posedge clk_p) begin
        #1 rd_data = ram[addr_q];
    end

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED t=%0t %s: got %0h expected %0h", $time, msg, actual,
                     expected);
        end
    endtask

    task automatic fill_image(input img_kind_t kind, input int param);
        int x;
        int y;
        int v;
        for (int a = 0; a < depth; a++) begin
            x = a % img_w;
            y = a / img_w;
            case (kind)
                k_flat:    v = param;
                k_ramp:    v = x * param;
                k_stripes: v = ((x >> 1) & 1) ? param : 255 - param;
                k_random:  v = $urandom;
                default:   v = (((x >> 1) + (y >> 1)) & 1) ? param : 0;
            endcase
            ram[a] = pix_t'(v);
        end
    endtask

    // ------------------------------
    // one frame from load through the emitted pixels
    task automatic run_frame(input int r);
        int n;
        int a;
        fill_image(table_rows[r].kind, table_rows[r].param);
        build_model();
        @(negedge clk_p);
        if (r > 0) check_value(done, 1, "done held until the next start");
        @(posedge clk_p);
        #1 start = 1'b1;
        @(posedge clk_p);
        #1 start = 1'b0;
        @(negedge clk_p);
        check_value(done, 0, "done falls after start");
        // raw reads run in address order even across a stray start
        for (int k = 0; k < depth; k++) begin
            check_value(rd_addr, k, $sformatf("frame %0d load rd_addr", r));
            @(posedge clk_p);
            #1 start = (k == 20);
            @(negedge clk_p);
        end
        n = 0;
        while (out_valid !== 1'b1) begin
            @(negedge clk_p);
        end
        while (out_valid === 1'b1) begin
            a = (2 + n / (img_w - 4)) * img_w + 2 + n % (img_w - 4);
            check_value(wr_addr, a, $sformatf("frame %0d beat %0d wr_addr", r, n));
            check_value(pixel_out, (mr[a] << 16) | (mg[a] << 8) | mb[a],
                        $sformatf("frame %0d pixel x=%0d y=%0d", r, a % img_w, a / img_w));
            n++;
            @(negedge clk_p);
        end
        check_value(n, table_rows[r].count, $sformatf("frame %0d beat count", r));
        check_value(done, 1, "done after the last beat");
        repeat (3) begin
            @(negedge clk_p);
            check_value(done, 1, "done stays high");
            check_value(out_valid, 0, "out_valid stays low after the frame");
        end
    endtask

    initial begin
        errors = 0;
        checks = 0;
        rst = 1'b1;
        start = 1'b0;
        rd_data = '0;
        addr_q = '0;
        void'($urandom(8043));
        table_rows[0] = '{k_flat, 100, beats};
        table_rows[1] = '{k_ramp, 16, beats};
        table_rows[2] = '{k_stripes, 200, beats};
        table_rows[3] = '{k_random, 0, beats};
        table_rows[4] = '{k_checker, 255, beats};
        repeat (10) @(posedge clk_p);
        #1 rst = 1'b0;
        @(negedge clk_p);
        check_value(out_valid, 0, "out_valid low after reset");
        check_value(done, 0, "done low after reset");
        check_value(rd_addr, 0, "rd_addr zero after reset");
        for (int r = 0; r < n_rows; r++) begin
            run_frame(r);
        end
        $display("errors %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        #(clk_period * (n_rows * frame_cycles + 100));
        $display("timeout: the frames did not complete in the expected time");
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire
